// File: uartRxPkg.sv
// UART receiver shared types, constants and the BIST LFSR step
`default_nettype none

package uartRxPkg;

        //////////////////////////////
        // Constants
        //////////////////////////////
        localparam int dataBits = 8;                            // Character width
        localparam logic [dataBits-1:0] lfsrSeed = 8'hA5;       // BIST LFSR start value

        //////////////////////////////
        // Types
        //////////////////////////////
        typedef enum logic [1:0] {
                regDivisor = 2'd0,                              // Clock cycles per bit
                regControl = 2'd1                               // Bit 0 BIST, bit 1 clear overrun
        } regAddr_e;

        typedef struct packed {
                logic [15:0] divisor;                           // Cycles per serial bit
                logic        bistMode;
                logic        clearOverrun;                      // One-cycle pulse
        } uartCfg_t;

        typedef struct packed {
                logic [dataBits-1:0] data;
                logic                valid;                     // Good frame strobe
                logic                frameErr;                  // Bad stop bit strobe
        } rxEvent_t;

        typedef struct packed {
                logic empty;
                logic halfFull;
                logic full;
                logic overrun;                                  // Sticky until cleared
        } fifoStatus_t;

        typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_e;
        typedef enum logic [1:0] {bistIdle, bistSend, bistWait, bistDone} bistState_e;

        // Galois-free Fibonacci step, taps 8,6,5,4
        function automatic logic [dataBits-1:0] lfsrNext(input logic [dataBits-1:0] v);
                return {v[dataBits-2:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
        endfunction

endpackage

`default_nettype wire

// File: uartRxRegs.sv
// Configuration registers for divisor, BIST mode and the overrun clear pulse
`timescale 1ns/1ns
`default_nettype none

module uartRxRegs (
        input  logic                 Data_Rdy,
        input  logic                 Pop_Data,
        input  logic                 regWrite,
        input  uartRxPkg::regAddr_e  regAddr,
        input  logic [15:0]          regWdata,
        output uartRxPkg::uartCfg_t  cfg
);
        import uartRxPkg::*;

        //////////////////////////////
        // Register writes
        //////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        cfg.divisor      <= 16'd16;             // Default bit time
                        cfg.bistMode     <= 1'b0;
                        cfg.clearOverrun <= 1'b0;
                end else begin
                        cfg.clearOverrun <= 1'b0;               // Pulse lasts one cycle
                        if (regWrite) begin
                                case (regAddr)
                                        regDivisor: begin
                                                cfg.divisor <= regWdata;
                                        end
                                        regControl: begin
                                                cfg.bistMode     <= regWdata[0];
                                                cfg.clearOverrun <= regWdata[1];
                                        end
                                        default: begin
                                                cfg.divisor <= cfg.divisor; // Unmapped address
                                        end
                                endcase
                        end
                end
        end

endmodule

`default_nettype wire

// File: uartRxDeserializer.sv
// Oversampling framer that turns the serial line into byte and frame error strobes
`timescale 1ns/1ns
`default_nettype none

module uartRxDeserializer (
        input  logic                 Data_Rdy,
        input  logic                 Pop_Data,
        input  logic                 serialIn,
        input  logic [15:0]          divisor,
        output uartRxPkg::rxEvent_t  rxEvent
);
        import uartRxPkg::*;

        localparam int idxBits = $clog2(dataBits);
        localparam logic [idxBits-1:0] lastIdx = idxBits'(dataBits - 1);

        logic [2:0]          syncQ;                             // Two sync flops plus edge history
        logic                lineBit;
        logic                startEdge;
        logic                sampleNow;                         // Full bit time elapsed
        logic [15:0]         bitTimer;
        logic [idxBits-1:0]  bitIdx;
        logic [dataBits-1:0] shiftReg;
        rxState_e            state;

        //////////////////////////////
        // Synchronizer
        //////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        syncQ <= '1;                            // Line idles high
                end else begin
                        syncQ <= {syncQ[1:0], serialIn};
                end
        end

        assign lineBit   = syncQ[1];
        assign startEdge = syncQ[2] & ~syncQ[1];                // Falling edge
        assign sampleNow = (bitTimer >= divisor);

        //////////////////////////////
        // Framing FSM
        //////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        state    <= rxIdle;
                        bitTimer <= '0;
                        bitIdx   <= '0;
                        rxEvent  <= '0;
                end else begin
                        rxEvent.valid    <= 1'b0;
                        rxEvent.frameErr <= 1'b0;
                        bitTimer         <= bitTimer + 16'd1;
                        case (state)
                                rxIdle: begin
                                        bitTimer <= 16'd1;
                                        if (startEdge) state <= rxStart;
                                end
                                rxStart: begin
                                        // Mid start bit check
                                        if (bitTimer >= {1'b0, divisor[15:1]}) begin
                                                bitTimer <= 16'd1;
                                                bitIdx   <= '0;
                                                state    <= lineBit ? rxIdle : rxData; // False start
                                        end
                                end
                                rxData: begin
                                        if (sampleNow) begin
                                                bitTimer <= 16'd1;
                                                bitIdx   <= bitIdx + 1'b1;
                                                if (bitIdx == lastIdx) state <= rxStop;
                                        end
                                end
                                rxStop: begin
                                        if (sampleNow) begin
                                                rxEvent.data     <= shiftReg;
                                                rxEvent.valid    <= lineBit;    // Good stop bit
                                                rxEvent.frameErr <= ~lineBit;
                                                state            <= rxIdle;
                                        end
                                end
                                default: state <= rxIdle;
                        endcase
                end
        end

        // Data bits arrive LSB first
        always_ff @(posedge Data_Rdy) begin
                if (state == rxData && sampleNow) shiftReg <= {lineBit, shiftReg[dataBits-1:1]};
        end

endmodule

`default_nettype wire

// File: rxFifo.sv
// Receive FIFO with empty, half-full, full and sticky overrun flags and a BIST freeze
`timescale 1ns/1ns
`default_nettype none

module rxFifo #(
        parameter int fifoAddrBits = 4
) (
        input  logic                           Data_Rdy,
        input  logic                           Pop_Data,
        input  uartRxPkg::rxEvent_t            rxEvent,
        input  logic                           popReq,
        input  logic                           bistMode,
        input  logic                           clearOverrun,
        output uartRxPkg::fifoStatus_t         status,
        output logic [uartRxPkg::dataBits-1:0] dataOut
);
        import uartRxPkg::*;

        localparam logic [fifoAddrBits:0] depth    = {1'b1, {fifoAddrBits{1'b0}}};
        localparam logic [fifoAddrBits:0] halfMark = {2'b01, {(fifoAddrBits-1){1'b0}}};

        logic [dataBits-1:0]     fifoMem [2**fifoAddrBits];
        logic [fifoAddrBits-1:0] rdPtr;
        logic [fifoAddrBits-1:0] wrPtr;
        logic [fifoAddrBits:0]   count;                         // One extra bit for full
        logic                    overrun;
        logic                    doWrite;
        logic                    doPop;
        logic                    dropByte;

        //////////////////////////////
        // Strobe decode
        //////////////////////////////
        assign doWrite  = !bistMode && rxEvent.valid && (count < depth);
        assign dropByte = !bistMode && rxEvent.valid && (count == depth); // Back-pressure
        // Write wins over a pop in the same cycle
        assign doPop    = !bistMode && popReq && !rxEvent.valid && (count != '0);

        always_ff @(posedge Data_Rdy) begin
                if (doWrite) fifoMem[wrPtr] <= rxEvent.data;
        end

        //////////////////////////////
        // Pointers, count and flags
        //////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        rdPtr   <= '0;
                        wrPtr   <= '0;
                        count   <= '0;
                        overrun <= 1'b0;
                        dataOut <= '0;
                end else begin
                        if (doWrite) begin
                                wrPtr <= wrPtr + 1'b1;
                                count <= count + 1'b1;
                        end else if (doPop) begin
                                dataOut <= fifoMem[rdPtr];      // Head byte out
                                rdPtr   <= rdPtr + 1'b1;
                                count   <= count - 1'b1;
                        end
                        if (!bistMode) begin                    // Frozen in BIST
                                if (clearOverrun) overrun <= 1'b0;
                                else if (dropByte) overrun <= 1'b1;
                        end
                end
        end

        always_comb begin
                status.empty    = (count == '0);
                status.halfFull = (count >= halfMark);
                status.full     = (count == depth);             // Clears on the next pop
                status.overrun  = overrun;
        end

endmodule

`default_nettype wire

// File: rxBist.sv
// Self-test engine that sends an LFSR byte stream over loopback and checks it back
`timescale 1ns/1ns
`default_nettype none

module rxBist #(
        parameter int bistBytes = 8
) (
        input  logic                 Data_Rdy,
        input  logic                 Pop_Data,
        input  logic                 bistMode,
        input  logic [15:0]          divisor,
        input  uartRxPkg::rxEvent_t  rxEvent,
        output logic                 bistTx,
        output logic                 bistDone,
        output logic                 bistPass
);
        import uartRxPkg::*;

        localparam int cntBits = $clog2(bistBytes + 1);
        localparam logic [cntBits-1:0] lastByte = cntBits'(bistBytes - 1);
        localparam logic [cntBits-1:0] allBytes = cntBits'(bistBytes);

        bistState_e          state;
        logic                modeQ;                             // For the rising edge
        logic [dataBits-1:0] txLfsr;
        logic [dataBits-1:0] expLfsr;
        logic [dataBits+1:0] txShift;                           // Stop, data, start
        logic [3:0]          txBitCnt;
        logic [15:0]         txTimer;
        logic [cntBits-1:0]  sentCnt;
        logic [cntBits-1:0]  rcvdCnt;
        logic                mismatch;

        assign bistTx   = txShift[0];
        // Port name hides the state literal, so it is scoped
        assign bistDone = (state == uartRxPkg::bistDone);
        assign bistPass = bistDone && !mismatch;

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        state    <= bistIdle;
                        modeQ    <= 1'b0;
                        txLfsr   <= lfsrSeed;
                        expLfsr  <= lfsrSeed;
                        txShift  <= '1;
                        txBitCnt <= '0;
                        txTimer  <= '0;
                        sentCnt  <= '0;
                        rcvdCnt  <= '0;
                        mismatch <= 1'b0;
                end else begin
                        modeQ <= bistMode;
                        //////////////////////////////
                        // Transmit side
                        //////////////////////////////
                        if (!bistMode) begin                    // Back to idle, line high
                                state    <= bistIdle;
                                txLfsr   <= lfsrSeed;
                                expLfsr  <= lfsrSeed;
                                txShift  <= '1;
                                sentCnt  <= '0;
                                rcvdCnt  <= '0;
                                mismatch <= 1'b0;
                        end else if (state == bistIdle && !modeQ) begin
                                state    <= bistSend;
                                txShift  <= {1'b1, txLfsr, 1'b0};
                                txBitCnt <= '0;
                                txTimer  <= 16'd1;
                        end else if (state == bistSend) begin
                                txTimer <= txTimer + 16'd1;
                                if (txTimer >= divisor) begin   // Bit time over
                                        txTimer  <= 16'd1;
                                        txShift  <= {1'b1, txShift[dataBits+1:1]};
                                        txBitCnt <= txBitCnt + 4'd1;
                                        if (txBitCnt == 4'(dataBits + 1)) begin
                                                sentCnt  <= sentCnt + 1'b1;
                                                txLfsr   <= lfsrNext(txLfsr);
                                                txBitCnt <= '0;
                                                txShift  <= {1'b1, lfsrNext(txLfsr), 1'b0};
                                                if (sentCnt == lastByte) begin
                                                        state   <= bistWait;
                                                        txShift <= '1;
                                                end
                                        end
                                end
                        end else if (state == bistWait && rcvdCnt == allBytes) begin
                                state <= uartRxPkg::bistDone;
                        end

                        //////////////////////////////
                        // Receive check
                        //////////////////////////////
                        if (bistMode && (state == bistSend || state == bistWait)) begin
                                if (rxEvent.valid || rxEvent.frameErr) begin
                                        expLfsr <= lfsrNext(expLfsr);
                                        rcvdCnt <= rcvdCnt + 1'b1;
                                        if (rxEvent.frameErr || rxEvent.data != expLfsr)
                                                mismatch <= 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// File: uartRxTop.sv
// UART receiver top with registers, framer, receive FIFO, BIST and loopback mux
`timescale 1ns/1ns
`default_nettype none

module uartRxTop #(
        parameter int fifoAddrBits = 4,
        parameter int bistBytes    = 8
) (
        input  logic                           Data_Rdy,
        input  logic                           Pop_Data,
        input  logic                           rxLine,
        input  logic                           regWrite,
        input  uartRxPkg::regAddr_e            regAddr,
        input  logic [15:0]                    regWdata,
        input  logic                           popReq,
        output logic [uartRxPkg::dataBits-1:0] dataOut,
        output uartRxPkg::fifoStatus_t         status,
        output logic                           frameErrSeen,
        output logic                           bistDone,
        output logic                           bistPass
);
        import uartRxPkg::*;

        uartCfg_t cfg;
        rxEvent_t rxEvent;
        logic     bistTx;
        logic     serialLine;

        assign serialLine = cfg.bistMode ? bistTx : rxLine;     // Internal loopback

        // Sticky frame error, BIST frames report through bistPass
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        frameErrSeen <= 1'b0;
                end else if (cfg.clearOverrun) begin
                        frameErrSeen <= 1'b0;
                end else if (rxEvent.frameErr && !cfg.bistMode) begin
                        frameErrSeen <= 1'b1;
                end
        end

        //////////////////////////////
        // Blocks
        //////////////////////////////
        uartRxRegs u_uartRxRegs (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .regWrite (regWrite),
                .regAddr  (regAddr),
                .regWdata (regWdata),
                .cfg      (cfg)
        );

        uartRxDeserializer u_uartRxDeserializer (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .serialIn (serialLine),
                .divisor  (cfg.divisor),
                .rxEvent  (rxEvent)
        );

        rxFifo #(.fifoAddrBits(fifoAddrBits)) u_rxFifo (
                .Data_Rdy     (Data_Rdy),
                .Pop_Data     (Pop_Data),
                .rxEvent      (rxEvent),
                .popReq       (popReq),
                .bistMode     (cfg.bistMode),
                .clearOverrun (cfg.clearOverrun),
                .status       (status),
                .dataOut      (dataOut)
        );

        rxBist #(.bistBytes(bistBytes)) u_rxBist (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .bistMode (cfg.bistMode),
                .divisor  (cfg.divisor),
                .rxEvent  (rxEvent),
                .bistTx   (bistTx),
                .bistDone (bistDone),
                .bistPass (bistPass)
        );

endmodule

`default_nettype wire

// File: tb_uartRxTop.sv
// Testbench for the UART receiver: framing, FIFO flags, overrun, frame error and BIST
`timescale 1ns/1ns
`default_nettype none

module tb_uartRxTop;
        import uartRxPkg::*;

        localparam int entries    = 16;                         // Default FIFO depth
        localparam int frameCount = 43;                         // All frames, BIST loopback too
        localparam int watchdogNs = frameCount * 10 * 16 * 4 * 2;
        localparam int bistFrames = 8;

        logic                Data_Rdy;
        logic                Pop_Data;
        logic                rxLine;
        logic                regWrite;
        regAddr_e            regAddr;
        logic [15:0]         regWdata;
        logic                popReq;
        logic [dataBits-1:0] dataOut;
        fifoStatus_t         status;
        logic                frameErrSeen;
        logic                bistDone;
        logic                bistPass;

        int                  seed = 77997;
        int                  errCount = 0;
        int                  checkCount = 0;
        int                  curDiv = 16;                       // Tracks the divisor register
        string               testName = "reset";
        logic [dataBits-1:0] expQ [$];                          // Model of the FIFO contents
        logic                modelOverrun = 1'b0;
        logic [dataBits-1:0] modelOut = '0;                     // Last byte popped
        logic                clearWrite;                        // Control write with clear bit

        uartRxTop u_uartRxTop (
                .Data_Rdy     (Data_Rdy),
                .Pop_Data     (Pop_Data),
                .rxLine       (rxLine),
                .regWrite     (regWrite),
                .regAddr      (regAddr),
                .regWdata     (regWdata),
                .popReq       (popReq),
                .dataOut      (dataOut),
                .status       (status),
                .frameErrSeen (frameErrSeen),
                .bistDone     (bistDone),
                .bistPass     (bistPass)
        );

        initial Data_Rdy = 1'b0;
        always #2 Data_Rdy = ~Data_Rdy;                         // 4 ns period

        assign clearWrite = regWrite && (regAddr == regControl) && regWdata[1];

        //////////////////////////////
        // Concurrent checks
        //////////////////////////////
        // Sticky flags only drop two cycles after a clear write
        overrunSticky: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                $fell(status.overrun) |-> $past(clearWrite, 2))
                else begin
                        errCount++;
                        $display("Overrun flag dropped without a clear write");
                end

        frameErrSticky: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                $fell(frameErrSeen) |-> $past(clearWrite, 2))
                else begin
                        errCount++;
                        $display("Frame error flag dropped without a clear write");
                end

        //////////////////////////////
        // Checking tasks
        //////////////////////////////
        task automatic checkEq(input string what, input int expVal, input int actVal);
                checkCount++;
                assert (expVal == actVal) else begin
                        errCount++;
                        $display("** Error %s %s: expected %0h, actual %0h",
                                 testName, what, expVal, actVal);
                end
        endtask

        // Flags follow from the model count
        function automatic fifoStatus_t expectedStatus();
                fifoStatus_t expStat;
                expStat.empty    = (expQ.size() == 0);
                expStat.halfFull = (expQ.size() >= entries / 2);
                expStat.full     = (expQ.size() == entries);
                expStat.overrun  = modelOverrun;
                return expStat;
        endfunction

        task automatic checkStatus();
                checkEq("status", int'(expectedStatus()), int'(status));
        endtask

        task automatic modelRx(input logic [dataBits-1:0] b);
                if (expQ.size() < entries) expQ.push_back(b);
                else modelOverrun = 1'b1;                       // Dropped byte
        endtask

        //////////////////////////////
        // Drivers
        //////////////////////////////
        // Entered and left 1 ns after a rising edge
        task automatic holdBit(input logic b);
                rxLine = b;
                repeat (curDiv) @(posedge Data_Rdy);
                #1;
        endtask

        // Start, 8 data bits LSB first, stop; the stop sample lands half a bit early
        task automatic sendFrame(input logic [dataBits-1:0] data, input logic stopBit);
                holdBit(1'b0);
                for (int i = 0; i < dataBits; i++) holdBit(data[i]);
                holdBit(stopBit);
                rxLine = 1'b1;
        endtask

        task automatic sendBytes(input int n);
                logic [dataBits-1:0] b;
                for (int k = 0; k < n; k++) begin
                        b = 8'($random(seed));
                        sendFrame(b, 1'b1);
                        modelRx(b);
                        checkStatus();
                end
        endtask

        task automatic writeReg(input regAddr_e addr, input logic [15:0] data);
                regAddr  = addr;
                regWdata = data;
                regWrite = 1'b1;
                @(posedge Data_Rdy);
                #1;
                regWrite = 1'b0;                                // Value now in the config
        endtask

        // Pulse clears overrun and frameErrSeen one cycle after the config update
        task automatic clearFlags();
                writeReg(regControl, 16'h0002);
                @(posedge Data_Rdy);
                #1;
                modelOverrun = 1'b0;
        endtask

        task automatic popCheck();
                popReq = 1'b1;
                @(posedge Data_Rdy);
                #1;
                popReq = 1'b0;
                if (expQ.size() > 0) modelOut = expQ.pop_front(); // Empty pop keeps dataOut
                checkEq("dataOut", int'(modelOut), int'(dataOut));
                checkStatus();
        endtask

        // Pops held high all through BIST must change nothing
        task automatic runBist();
                int cycles;
                int limit;
                limit  = 2 * bistFrames * 10 * curDiv;
                cycles = 0;
                writeReg(regControl, 16'h0001);
                popReq = 1'b1;
                while (!bistDone && cycles < limit) begin
                        @(posedge Data_Rdy);
                        #1;
                        cycles++;
                        checkEq("held dataOut", int'(modelOut), int'(dataOut));
                        checkEq("held status", int'(expectedStatus()), int'(status));
                end
                popReq = 1'b0;
                if (!bistDone) begin
                        errCount++;
                        $display("BIST did not finish within %0d cycles", limit);
                end
                checkEq("bistPass", 1, int'(bistPass));
                writeReg(regControl, 16'h0000);
                @(posedge Data_Rdy);                            // Engine sees the mode drop
                #1;
                checkEq("bistDone after exit", 0, int'(bistDone));
        endtask

        //////////////////////////////
        // Test sequence
        //////////////////////////////
        initial begin
                rxLine   = 1'b1;                                // Idle line
                regWrite = 1'b0;
                regAddr  = regDivisor;
                regWdata = '0;
                popReq   = 1'b0;
                Pop_Data = 1'b1;
                repeat (5) @(posedge Data_Rdy);
                #1;
                Pop_Data = 1'b0;

                testName = "reset";
                checkStatus();
                checkEq("dataOut", 0, int'(dataOut));
                checkEq("bistDone", 0, int'(bistDone));
                checkEq("bistPass", 0, int'(bistPass));

                testName = "ordering";
                sendBytes(10);                                  // halfFull from the 8th on
                holdBit(1'b1);
                while (expQ.size() > 0) popCheck();

                testName = "overrun";
                sendBytes(17);                                  // 17th is dropped
                holdBit(1'b1);
                popCheck();                                     // full clears, overrun stays
                clearFlags();
                checkStatus();
                while (expQ.size() > 0) popCheck();

                testName = "frame error";
                sendFrame(8'h3C, 1'b0);
                holdBit(1'b1);
                holdBit(1'b1);                                  // Line back high before next start
                checkEq("frameErrSeen", 1, int'(frameErrSeen));
                checkStatus();
                sendBytes(1);
                holdBit(1'b1);
                popCheck();
                clearFlags();
                checkEq("frameErrSeen after clear", 0, int'(frameErrSeen));

                testName = "divisor";
                writeReg(regDivisor, 16'd9);
                curDiv = 9;
                sendBytes(4);
                holdBit(1'b1);
                while (expQ.size() > 0) popCheck();
                popCheck();                                     // Pop on empty

                testName = "bist";
                sendBytes(2);
                holdBit(1'b1);
                runBist();
                while (expQ.size() > 0) popCheck();
                checkStatus();

                $display("Checks: %0d, errors: %0d", checkCount, errCount);
                if (errCount == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

        // Run length bound from frame count, bit count and the slowest divisor
        initial begin
                #(watchdogNs);
                $display("Watchdog expired after %0d ns, the run is stuck", watchdogNs);
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

// File: tb.f
uartRxPkg.sv
uartRxRegs.sv
uartRxDeserializer.sv
rxFifo.sv
rxBist.sv
uartRxTop.sv
tb_uartRxTop.sv

// File: Makefile
TOP := tb_uartRxTop
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "No result in log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
